//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_fetch_top
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- fetch_if.sv
/* word stream from the prefetch buffer to the fetch stage; branch wins over a
   pending transfer, the target address travels outside this bundle */
`timescale 1ns/1ps

interface fetch_if;
  import fetch_pkg::*;

  // word on rdata/addr is available, held until taken or flushed
  logic   valid;
  // fetch stage takes the word at this edge
  logic   ready;
  instr_t rdata;
  addr_t  addr;
  // redirect, flushes buffered words
  logic   branch;

  modport source (
    output valid, rdata, addr,
    input  ready, branch
  );

  modport sink (
    input  valid, rdata, addr,
    output ready, branch
  );

endinterface

//--- fetch_patterns.txt
# pc_mux exc_pc_mux exc_cause jump_target mepc depc n stall first_pc (all hex)
# line 1 starts fetching by req_i, later lines redirect with pc_set_i
# boot entry, boot base 0x00001000 plus offset 0x80
0 0 00 00000000 00000000 00000000 4 0 00001080
# jump
1 0 00 00004000 00006100 00007200 3 0 00004000
# return from trap
3 0 00 00004000 00006100 00007200 3 0 00006100
# return from debug
4 0 00 00004000 00006100 00007200 3 0 00007200
# exception vector at the boot base
2 0 00 00004000 00006100 00007200 3 0 00001000
# interrupt id 5
2 1 25 00004000 00006100 00007200 3 0 00001014
# debug halt entry
2 2 00 00004000 00006100 00007200 2 0 1a110800
# debug exception entry
2 3 00 00004000 00006100 00007200 2 0 1a110808
# jump with back-pressure and valid clear
1 0 00 00008000 00006100 00007200 6 1 00008000
# back to the boot entry through pc_set_i
0 0 00 00004000 00006100 00007200 2 0 00001080
# return from trap with back-pressure
3 0 00 00004000 0000a000 00007200 5 1 0000a000
# interrupt id 31, then a long run
2 1 3f 00004000 00006100 00007200 8 0 0000107c

//--- fetch_pkg.sv
/* shared types for the fetch subsystem; instructions are 32-bit and word aligned,
   and the boot address is assumed 256-byte aligned */
package fetch_pkg;

  // byte address, used for pcs and memory addresses
  typedef logic [31:0] addr_t;
  // one uncompressed instruction word
  typedef logic [31:0] instr_t;
  // bit 5 marks an interrupt, bits 4:0 hold the interrupt id
  typedef logic [5:0]  exc_cause_t;

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // trap vector source
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // memory request fsm, one request in flight at most
  typedef enum logic [1:0] {
    PF_IDLE,
    PF_WAIT_GNT,
    PF_WAIT_RVALID
  } pf_state_e;

  // debug module entry points
  localparam addr_t       DM_HALT_ADDR = 32'h1A110800;
  localparam addr_t       DM_EXC_ADDR  = 32'h1A110808;
  // buffered words, kept a power of two
  localparam int unsigned FIFO_DEPTH   = 2;
  // reset entry inside the boot region
  localparam logic [7:0]  BOOT_OFFSET  = 8'h80;

endpackage

//--- fetch_top.f
fetch_pkg.sv
fetch_if.sv
prefetch_fifo.sv
prefetch_buffer.sv
if_stage.sv
fetch_top.sv
fetch_top_sva.sv
tb_fetch_top.sv

//--- fetch_top.sv
/* instruction fetch subsystem top; memory port is request, grant, then
   rvalid, with one request in flight */
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  // control from the decode stage
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  // towards the decode stage
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       pc_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  // instruction memory port
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  output logic                   if_busy_o
);
  import fetch_pkg::*;

  // redirect target from the fetch stage
  addr_t branch_addr;

  fetch_if fetch_bus ();

  if_stage i_if_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_cause_i         (exc_cause_i),
    .jump_target_i       (jump_target_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch               (fetch_bus.sink),
    .branch_addr_o       (branch_addr),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

  prefetch_buffer i_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_addr_i  (branch_addr),
    .fetch          (fetch_bus.source),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (if_busy_o)
  );

endmodule

//--- fetch_top_sva.sv
/* memory port and decode-side checks, bound into every fetch_top instance */
`timescale 1ns/1ps

module fetch_top_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             instr_req_o,
  input logic             instr_gnt_i,
  input fetch_pkg::addr_t instr_addr_o,
  input logic             instr_valid_id_o
);

  // a request stays up with its address until the memory grants it
  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("request dropped or address changed before the grant");

  // all fetches are word aligned, no compressed support
  req_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("request address not word aligned");

  // decode sees nothing in the first cycle out of reset
  no_valid_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !instr_valid_id_o)
    else $error("instr_valid_id_o high right after reset");

endmodule

bind fetch_top fetch_top_sva i_fetch_top_sva (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .instr_req_o      (instr_req_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_addr_o     (instr_addr_o),
  .instr_valid_id_o (instr_valid_id_o)
);

//--- if_stage.sv
/* pc selection and IF-ID register; boot_addr_i[7:0] is ignored and only cause
   bits 4:0 pick the interrupt vector */
`timescale 1ns/1ps

module if_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  fetch_if.sink                  fetch,
  output fetch_pkg::addr_t       branch_addr_o,
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       pc_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o
);
  import fetch_pkg::*;

  addr_t boot_entry;
  addr_t exc_pc;
  addr_t fetch_addr_n;
  // no fetch started since reset
  logic  init_q;
  logic  if_id_we;

  //////////////////////////////////////////////////////////////////////
  // next pc selection
  //////////////////////////////////////////////////////////////////////

  assign boot_entry = {boot_addr_i[31:8], BOOT_OFFSET};

  // trap vectors sit in the boot region, debug ones are fixed
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {boot_addr_i[31:8], 8'h00};
      EXC_PC_IRQ:     exc_pc = {boot_addr_i[31:8], 1'b0, exc_cause_i[4:0], 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {boot_addr_i[31:8], 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n = boot_entry;
      PC_JUMP: fetch_addr_n = jump_target_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = boot_entry;
    endcase
  end

  // first req_i branches to the boot entry, pc_set_i redirects anytime
  assign fetch.branch  = pc_set_i | (init_q & req_i);
  assign branch_addr_o = pc_set_i ? fetch_addr_n : boot_entry;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q <= 1'b1;
    end else if (fetch.branch) begin
      init_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // IF-ID pipeline register
  //////////////////////////////////////////////////////////////////////

  // words in flight are stale during a redirect
  assign fetch.ready = id_in_ready_i & ~pc_set_i;
  assign if_id_we    = fetch.valid & fetch.ready;
  assign pc_if_o     = fetch.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_new_id_o <= if_id_we;
      // a load wins over a clear at the same edge
      if (if_id_we) begin
        instr_valid_id_o <= 1'b1;
      end else if (instr_valid_clear_i) begin
        instr_valid_id_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_id_we) begin
      pc_id_o          <= fetch.addr;
      instr_rdata_id_o <= fetch.rdata;
    end
  end

endmodule

//--- prefetch_buffer.sv
/* one outstanding memory request at a time; a request is only issued while the
   FIFO has a free slot, responses that predate a branch are dropped */
`timescale 1ns/1ps

module prefetch_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  fetch_pkg::addr_t  branch_addr_i,
  fetch_if.source           fetch,
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  output logic              busy_o
);
  import fetch_pkg::*;

  pf_state_e state_q;
  pf_state_e state_d;
  // next word address to request
  addr_t     fetch_addr_q;
  // address of the request in flight
  addr_t     req_addr_q;
  // response in flight belongs to an old pc
  logic      discard_q;
  logic      gnt_ok;
  logic      push;
  logic      fifo_pop;
  logic      fifo_full;

  assign gnt_ok   = instr_req_o & instr_gnt_i;
  // a response landing with a branch is stale as well
  assign push     = instr_rvalid_i & ~discard_q & ~fetch.branch;
  assign fifo_pop = fetch.valid & fetch.ready;
  assign busy_o   = (state_q != PF_IDLE);

  // address held stable while waiting for the grant
  assign instr_addr_o = (state_q == PF_WAIT_GNT) ? req_addr_q : fetch_addr_q;

  //////////////////////////////////////////////////////////////////////
  // request fsm
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    unique case (state_q)
      PF_IDLE: begin
        // no request during a branch, fetch_addr_q is not loaded yet
        if (req_i && !fetch.branch && !fifo_full) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? PF_WAIT_RVALID : PF_WAIT_GNT;
        end
      end
      PF_WAIT_GNT: begin
        // request must stay up until granted
        instr_req_o = 1'b1;
        if (instr_gnt_i) begin
          state_d = PF_WAIT_RVALID;
        end
      end
      PF_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = PF_IDLE;
        end
      end
      default: state_d = PF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // addresses and stale response tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (fetch.branch) begin
      fetch_addr_q <= branch_addr_i;
    end else if (gnt_ok && !discard_q) begin
      // step only for grants on the current stream
      fetch_addr_q <= fetch_addr_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == PF_IDLE && instr_req_o) begin
      req_addr_q <= fetch_addr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      discard_q <= 1'b0;
    end else if (fetch.branch) begin
      // mark the one response still to come, if any
      discard_q <= (state_q == PF_WAIT_GNT) ||
                   (state_q == PF_WAIT_RVALID && !instr_rvalid_i);
    end else if (instr_rvalid_i) begin
      discard_q <= 1'b0;
    end
  end

  prefetch_fifo i_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (fetch.branch),
    .push_i      (push),
    .push_addr_i (req_addr_q),
    .push_data_i (instr_rdata_i),
    .pop_i       (fifo_pop),
    .valid_o     (fetch.valid),
    .addr_o      (fetch.addr),
    .data_o      (fetch.rdata),
    .full_o      (fifo_full)
  );

endmodule

//--- prefetch_fifo.sv
/* small store of fetched words with their addresses; no overflow check, the
   writer must respect full_o, and FIFO_DEPTH must be a power of two */
`timescale 1ns/1ps

module prefetch_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              push_i,
  input  fetch_pkg::addr_t  push_addr_i,
  input  fetch_pkg::instr_t push_data_i,
  input  logic              pop_i,
  output logic              valid_o,
  output fetch_pkg::addr_t  addr_o,
  output fetch_pkg::instr_t data_o,
  output logic              full_o
);
  import fetch_pkg::*;

  // entry storage, no reset needed
  addr_t                           addr_q [FIFO_DEPTH];
  instr_t                          data_q [FIFO_DEPTH];
  // pointers wrap on their own width
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count_q;

  // head of the queue
  assign valid_o = (count_q != '0);
  assign addr_o  = addr_q[rd_ptr_q];
  assign data_o  = data_q[rd_ptr_q];
  assign full_o  = (32'(count_q) == FIFO_DEPTH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect drops everything buffered
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[wr_ptr_q] <= push_addr_i;
      data_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- tb_fetch_top.sv
/* reads fetch_patterns.txt from the working directory; the first pattern line
   must be the boot line since it raises req_i */
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int    MAX_PATTERNS = 32;
  localparam addr_t BOOT_BASE    = 32'h0000_1000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  addr_t       boot_addr_i;
  logic        req_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;
  addr_t       jump_target_i;
  addr_t       csr_mepc_i;
  addr_t       csr_depc_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  addr_t       pc_if_o;
  addr_t       pc_id_o;
  instr_t      instr_rdata_id_o;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        if_busy_o;

  // nine fields per pattern line
  logic [31:0] pat [MAX_PATTERNS][9];
  int          num_patterns;
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;
  integer      seed;
  // memory model state, -1 means no grant countdown running
  int          gnt_wait;
  int          rsp_wait;
  addr_t       rsp_addr;
  int          grant_count;

  fetch_top i_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_cause_i         (exc_cause_i),
    .jump_target_i       (jump_target_i),
    .csr_mepc_i          (csr_mepc_i),
    .csr_depc_i          (csr_depc_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .if_busy_o           (if_busy_o)
  );

  always #5 clk_i = ~clk_i;

  // watchdog
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: fetch did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instruction memory model
  //////////////////////////////////////////////////////////////////////

  // runs just after the falling edge so instr_req_o has settled
  always @(negedge clk_i) begin
    #1;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (rsp_wait > 0) begin
      // a granted request keeps the fetch side busy until its response
      check_flag(if_busy_o, 1'b1, "if_busy_o with a response pending");
      rsp_wait = rsp_wait - 1;
      if (rsp_wait == 0) begin
        instr_rvalid_i = 1'b1;
        // data is the inverted word address
        instr_rdata_i  = ~rsp_addr;
      end
    end else if (instr_req_o) begin
      if (gnt_wait < 0) begin
        gnt_wait = int'($unsigned($random(seed)) % 3);
      end
      if (gnt_wait == 0) begin
        instr_gnt_i = 1'b1;
        rsp_addr    = instr_addr_o;
        rsp_wait    = 1 + int'($unsigned($random(seed)) % 2);
        gnt_wait    = -1;
        grant_count = grant_count + 1;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end else begin
      gnt_wait = -1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_instr(input instr_t got, input instr_t exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic read_patterns();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [9];
    fd = $fopen("fetch_patterns.txt", "r");
    if (fd == 0) begin
      errors = errors + 1;
      $display("could not open fetch_patterns.txt");
    end else begin
      while (!$feof(fd) && num_patterns < MAX_PATTERNS) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (cnt == 9) begin
            for (int k = 0; k < 9; k++) begin
              pat[num_patterns][k] = f[k];
            end
            num_patterns = num_patterns + 1;
          end else begin
            errors = errors + 1;
            $display("pattern line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (num_patterns == 0) begin
      errors = errors + 1;
      $display("no pattern lines were read");
    end
  endtask

  // wait for a fresh IF-ID load and return the fetch pc seen just before it
  task automatic wait_new_instr(output addr_t pc_before_load);
    do begin
      pc_before_load = pc_if_o;
      @(negedge clk_i);
    end while (instr_new_id_o !== 1'b1);
  endtask

  // hold decode for 20 cycles, then clear valid and release
  task automatic stall_and_clear();
    addr_t  held_pc;
    instr_t held_instr;
    int     grants_before;
    held_pc       = pc_id_o;
    held_instr    = instr_rdata_id_o;
    grants_before = grant_count;
    id_in_ready_i = 1'b0;
    repeat (20) begin
      @(negedge clk_i);
      check_addr(pc_id_o, held_pc, "pc_id_o under stall");
      check_instr(instr_rdata_id_o, held_instr, "instr_rdata_id_o under stall");
      check_flag(instr_new_id_o, 1'b0, "instr_new_id_o under stall");
      check_flag(instr_valid_id_o, 1'b1, "instr_valid_id_o under stall");
    end
    // fifo is full by now and nothing is in flight
    check_flag(if_busy_o, 1'b0, "if_busy_o with the FIFO full");
    checks = checks + 1;
    if (grant_count - grants_before > 2) begin
      errors = errors + 1;
      $display("** Error at %0t: %0d grants under stall, expected at most 2",
               $time, grant_count - grants_before);
    end
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    check_flag(instr_valid_id_o, 1'b0, "instr_valid_id_o after clear");
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
  endtask

  task automatic run_pattern(input int p);
    addr_t exp_pc;
    addr_t if_pc;
    int    n;
    logic  stall;
    n      = int'(pat[p][6]);
    stall  = pat[p][7][0];
    exp_pc = pat[p][8];
    @(negedge clk_i);
    pc_mux_i      = pc_sel_e'(pat[p][0][2:0]);
    exc_pc_mux_i  = exc_pc_sel_e'(pat[p][1][1:0]);
    exc_cause_i   = pat[p][2][5:0];
    jump_target_i = pat[p][3];
    csr_mepc_i    = pat[p][4];
    csr_depc_i    = pat[p][5];
    id_in_ready_i = 1'b1;
    // first line boots through req_i, later ones redirect
    if (!req_i) begin
      req_i = 1'b1;
    end else begin
      pc_set_i = 1'b1;
    end
    @(negedge clk_i);
    pc_set_i = 1'b0;
    for (int i = 0; i < n; i++) begin
      wait_new_instr(if_pc);
      check_addr(if_pc, exp_pc, "pc_if_o before load");
      check_addr(pc_id_o, exp_pc, "pc_id_o");
      check_instr(instr_rdata_id_o, ~exp_pc, "instr_rdata_id_o");
      check_flag(instr_valid_id_o, 1'b1, "instr_valid_id_o");
      if (stall && i == 0) begin
        stall_and_clear();
      end
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  initial begin
    seed                = 32'h16c1;
    errors              = 0;
    checks              = 0;
    cycles              = 0;
    cycle_limit         = 100;
    num_patterns        = 0;
    gnt_wait            = -1;
    rsp_wait            = 0;
    rsp_addr            = '0;
    grant_count         = 0;
    rst_ni              = 1'b0;
    boot_addr_i         = BOOT_BASE;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    jump_target_i       = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    read_patterns();
    cycle_limit = 200 * num_patterns + 100;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int p = 0; p < num_patterns; p++) begin
      run_pattern(p);
    end
    repeat (5) @(negedge clk_i);
    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
